//--- Makefile
# Verilator flow for cpu_on_board

LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f src.f --top-module cpu_on_board

# The run passes only if the log holds the pass line
sim:
	verilator --binary --timing --assert -Wno-fatal -f src.f \
	    --top-module tb_cpu_on_board --Mdir obj_dir -o sim_tb
	./obj_dir/sim_tb | tee $(LOG)
	grep -qx "TEST OK" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- src.f
src/soc_pkg.sv
src/board_mem.sv
src/ps2_rx.sv
src/key_irq.sv
src/uart_tx.sv
src/bus_ctrl.sv
src/cpu_on_board.sv
tests/tb_clock.sv
tests/tb_cpu_on_board.sv

//--- src/board_mem.sv
`timescale 1ns/100ps

module board_mem
    import soc_pkg::*;
#(
    parameter int MEM_WORDS = 2048
) (
    input  logic              CLOCK_50,
    input  logic [word_w-1:0] pc,
    output logic [word_w-1:0] instr,
    input  logic              mem_we,
    input  logic              mem_re,
    input  logic [mem_aw-1:0] mem_addr,
    input  logic [word_w-1:0] mem_wdata,
    output logic [word_w-1:0] mem_rdata
);

    logic [word_w-1:0] mem [0:MEM_WORDS-1];
    logic [word_w-1:0] fetch_word;
    logic [mem_aw-1:0] fetch_idx;

    // Fetch is word aligned, low pc bits ignored
    assign fetch_idx  = pc[mem_aw+1:2];
    assign fetch_word = mem[fetch_idx];

    // Instruction port
    // Core expects the opposite byte order from the data side
    always_ff @(posedge CLOCK_50) begin
        instr <= {fetch_word[7:0],
                  fetch_word[15:8],
                  fetch_word[23:16],
                  fetch_word[31:24]};
    end

    // Data port, write has priority over read
    always_ff @(posedge CLOCK_50) begin
        if (mem_we) begin
            mem[mem_addr] <= mem_wdata;
        end else if (mem_re) begin
            mem_rdata <= mem[mem_addr];
        end
    end

endmodule

//--- src/bus_ctrl.sv
`timescale 1ns/100ps

module bus_ctrl
    import soc_pkg::*;
(
    input  logic              CLOCK_50,
    input  logic              KEY0,
    input  logic              bus_valid,
    input  logic              bus_write,
    input  logic [xlen-1:0]   bus_addr,
    input  logic [xlen-1:0]   bus_wdata,
    output logic              bus_ready,
    output logic [xlen-1:0]   bus_rdata,
    output logic              bus_rvalid,
    output logic              mem_we,
    output logic              mem_re,
    output logic [mem_aw-1:0] mem_addr,
    output logic [word_w-1:0] mem_wdata,
    input  logic [word_w-1:0] mem_rdata,
    output logic              tx_valid,
    output logic [7:0]        tx_data,
    input  logic              tx_ready,
    input  logic [key_w-1:0]  key_word
);

    typedef enum logic [1:0] {src_zero, src_mem, src_key} rd_src_t;

    logic [xlen-1:0] mem_off;
    logic            in_rom;
    logic            in_ram;
    logic            in_mem;
    logic            is_art;
    logic            is_key;
    logic            accept;
    rd_src_t         rd_src_q;

    // Range checks by unsigned offset
    assign mem_off = bus_addr - rom_base;
    assign in_rom  = (bus_addr - rom_base) < (ram_base - rom_base);
    assign in_ram  = (bus_addr - ram_base) < (rom_base + mem_bytes - ram_base);
    assign in_mem  = in_rom || in_ram;
    assign is_art  = (bus_addr == art_base);
    assign is_key  = (bus_addr == key_base);

    // Only console writes can stall
    assign bus_ready = !(bus_write && is_art) || tx_ready;
    assign accept    = bus_valid && bus_ready;

    assign mem_we    = accept && bus_write && in_mem;
    assign mem_re    = accept && !bus_write && in_mem;
    assign mem_addr  = mem_off[mem_aw+1:2];
    assign mem_wdata = bus_wdata[word_w-1:0];

    assign tx_valid  = bus_valid && bus_write && is_art;
    assign tx_data   = bus_wdata[7:0];

    // Remember where an accepted read goes
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            bus_rvalid <= 1'b0;
            rd_src_q   <= src_zero;
        end else begin
            bus_rvalid <= accept && !bus_write;
            if (accept && !bus_write && in_mem) begin
                rd_src_q <= src_mem;
            end else if (accept && !bus_write && is_key) begin
                rd_src_q <= src_key;
            end else begin
                rd_src_q <= src_zero;
            end
        end
    end

    // Memory data lands this cycle
    always_comb begin
        case (rd_src_q)
            src_mem: bus_rdata = {{(xlen - word_w){1'b0}}, mem_rdata};
            src_key: bus_rdata = {{(xlen - key_w){1'b0}}, key_word};
            default: bus_rdata = '0;
        endcase
    end

endmodule

//--- src/cpu_on_board.sv
`timescale 1ns/100ps

module cpu_on_board
    import soc_pkg::*;
#(
    parameter int MEM_WORDS = 2048,
    parameter int BAUD_DIV  = 434
) (
    input  logic              CLOCK_50,
    input  logic              KEY0,
    input  logic              PS2_CLK,
    input  logic              PS2_DAT,
    // Core fetch port
    input  logic [word_w-1:0] pc,
    output logic [word_w-1:0] instr,
    // Core data bus
    input  logic              bus_valid,
    input  logic              bus_write,
    input  logic [xlen-1:0]   bus_addr,
    input  logic [xlen-1:0]   bus_wdata,
    output logic              bus_ready,
    output logic [xlen-1:0]   bus_rdata,
    output logic              bus_rvalid,
    // Interrupt handshake
    input  logic              irq_ack,
    output logic [3:0]        irq_vector,
    // Board pins
    output logic              uart_txd,
    output logic              LEDR0,
    output logic [5:0]        LEDR_PC
);

    logic              mem_we;
    logic              mem_re;
    logic [mem_aw-1:0] mem_addr;
    logic [word_w-1:0] mem_wdata;
    logic [word_w-1:0] mem_rdata;
    logic              tx_valid;
    logic [7:0]        tx_data;
    logic              tx_ready;
    logic              scan_valid;
    logic [7:0]        scan_code;
    logic              released;
    logic [key_w-1:0]  key_word;
    logic              irq_pending;

    // Word index of the current fetch
    assign LEDR_PC = pc[7:2];
    assign LEDR0   = irq_pending;

    board_mem #(
        .MEM_WORDS(MEM_WORDS)
    ) i_board_mem (
        .CLOCK_50 (CLOCK_50),
        .pc       (pc),
        .instr    (instr),
        .mem_we   (mem_we),
        .mem_re   (mem_re),
        .mem_addr (mem_addr),
        .mem_wdata(mem_wdata),
        .mem_rdata(mem_rdata)
    );

    bus_ctrl i_bus_ctrl (
        .CLOCK_50  (CLOCK_50),
        .KEY0      (KEY0),
        .bus_valid (bus_valid),
        .bus_write (bus_write),
        .bus_addr  (bus_addr),
        .bus_wdata (bus_wdata),
        .bus_ready (bus_ready),
        .bus_rdata (bus_rdata),
        .bus_rvalid(bus_rvalid),
        .mem_we    (mem_we),
        .mem_re    (mem_re),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata),
        .tx_valid  (tx_valid),
        .tx_data   (tx_data),
        .tx_ready  (tx_ready),
        .key_word  (key_word)
    );

    // Console
    uart_tx #(
        .BAUD_DIV(BAUD_DIV)
    ) i_uart_tx (
        .CLOCK_50(CLOCK_50),
        .KEY0    (KEY0),
        .tx_valid(tx_valid),
        .tx_data (tx_data),
        .tx_ready(tx_ready),
        .uart_txd(uart_txd)
    );

    // Keyboard path
    ps2_rx i_ps2_rx (
        .CLOCK_50  (CLOCK_50),
        .KEY0      (KEY0),
        .PS2_CLK   (PS2_CLK),
        .PS2_DAT   (PS2_DAT),
        .scan_valid(scan_valid),
        .scan_code (scan_code),
        .released  (released)
    );

    key_irq i_key_irq (
        .CLOCK_50   (CLOCK_50),
        .KEY0       (KEY0),
        .scan_valid (scan_valid),
        .scan_code  (scan_code),
        .released   (released),
        .irq_ack    (irq_ack),
        .key_word   (key_word),
        .irq_vector (irq_vector),
        .irq_pending(irq_pending)
    );

endmodule

//--- src/key_irq.sv
`timescale 1ns/100ps

module key_irq
    import soc_pkg::*;
(
    input  logic             CLOCK_50,
    input  logic             KEY0,
    input  logic             scan_valid,
    input  logic [7:0]       scan_code,
    input  logic             released,
    input  logic             irq_ack,
    output logic [key_w-1:0] key_word,
    output logic [3:0]       irq_vector,
    output logic             irq_pending
);

    logic [7:0] code_q;
    logic       make_q;
    logic       make_evt;

    assign make_evt = scan_valid && !released;

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            code_q     <= 8'd0;
            make_q     <= 1'b0;
            irq_vector <= irq_none;
        end else begin
            // Every event updates the key register
            if (scan_valid) begin
                code_q <= scan_code;
                make_q <= !released;
            end

            // A new press beats a same-cycle acknowledge
            if (make_evt) begin
                irq_vector <= irq_key;
            end else if (irq_ack && (irq_vector != irq_none)) begin
                irq_vector <= irq_none;
            end
        end
    end

    // Bit 8 is the make flag
    assign key_word    = {make_q, code_q};
    assign irq_pending = (irq_vector != irq_none);

endmodule

//--- src/ps2_rx.sv
`timescale 1ns/100ps

module ps2_rx
    import soc_pkg::*;
(
    input  logic       CLOCK_50,
    input  logic       KEY0,
    input  logic       PS2_CLK,
    input  logic       PS2_DAT,
    output logic       scan_valid,
    output logic [7:0] scan_code,
    output logic       released
);

    logic [1:0]  clk_sync;
    logic [1:0]  dat_sync;
    logic        clk_prev;
    logic        fall;
    logic [3:0]  bit_cnt;
    logic        frame_done;
    logic        brk_q;
    logic [10:0] frame_q;
    logic [7:0]  frame_code;
    logic        good_frame;
    logic        take_code;

    // Falling edge of the synchronised PS/2 clock
    assign fall = clk_prev && !clk_sync[1];

    // Frame layout: start, 8 data bits LSB first, odd parity, stop
    assign frame_code = frame_q[8:1];
    assign good_frame = !frame_q[0] && frame_q[10] && (^frame_q[9:1]);
    assign take_code  = frame_done && good_frame && (frame_code != ps2_break);

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            clk_sync   <= 2'b11;
            dat_sync   <= 2'b11;
            clk_prev   <= 1'b1;
            bit_cnt    <= 4'd0;
            frame_done <= 1'b0;
            brk_q      <= 1'b0;
            scan_valid <= 1'b0;
        end else begin
            clk_sync   <= {clk_sync[0], PS2_CLK};
            dat_sync   <= {dat_sync[0], PS2_DAT};
            clk_prev   <= clk_sync[1];
            frame_done <= 1'b0;
            scan_valid <= 1'b0;

            if (fall) begin
                if (bit_cnt == 4'd10) begin
                    bit_cnt    <= 4'd0;
                    frame_done <= 1'b1;
                end else begin
                    bit_cnt <= bit_cnt + 4'd1;
                end
            end

            // Break prefix only arms the flag for the next code
            if (frame_done && good_frame) begin
                if (frame_code == ps2_break) begin
                    brk_q <= 1'b1;
                end else begin
                    scan_valid <= 1'b1;
                    brk_q      <= 1'b0;
                end
            end
        end
    end

    // Shift register and reported code
    always_ff @(posedge CLOCK_50) begin
        if (fall) begin
            frame_q <= {dat_sync[1], frame_q[10:1]};
        end
        if (take_code) begin
            scan_code <= frame_code;
            released  <= brk_q;
        end
    end

endmodule

//--- src/soc_pkg.sv
package soc_pkg;

    // Bus and memory word widths
    localparam int xlen   = 64;
    localparam int word_w = 32;

    // Memory map
    localparam logic [xlen-1:0] rom_base  = 64'h0000_0000_0000_0000;
    localparam logic [xlen-1:0] ram_base  = 64'h0000_0000_0000_1000;
    localparam logic [xlen-1:0] mem_bytes = 64'h0000_0000_0000_2000;

    // Word index width covering the whole memory
    localparam int mem_aw = $clog2(mem_bytes / 4);

    // Console data register
    localparam logic [xlen-1:0] art_base = 64'h0000_0000_0000_2000;

    // Keyboard register, scan code plus make flag
    localparam logic [xlen-1:0] key_base = 64'h0000_0000_0000_2008;
    localparam int              key_w    = 9;

    // Interrupt vector codes
    localparam logic [3:0] irq_none = 4'd0;
    localparam logic [3:0] irq_key  = 4'd1;

    // PS/2 set 2 break prefix
    localparam logic [7:0] ps2_break = 8'hF0;

endpackage

//--- src/uart_tx.sv
`timescale 1ns/100ps

module uart_tx #(
    parameter int BAUD_DIV = 434
) (
    input  logic       CLOCK_50,
    input  logic       KEY0,
    input  logic       tx_valid,
    input  logic [7:0] tx_data,
    output logic       tx_ready,
    output logic       uart_txd
);

    localparam int cnt_w = $clog2(BAUD_DIV + 1);

    logic [cnt_w-1:0] baud_cnt;
    logic [3:0]       bit_cnt;
    logic [9:0]       shift_q;
    logic             busy;
    logic             bit_end;

    assign tx_ready = !busy;
    assign bit_end  = (baud_cnt == cnt_w'(BAUD_DIV - 1));

    // Line idles high since the shifter fills with ones
    assign uart_txd = shift_q[0];

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            baud_cnt <= '0;
            bit_cnt  <= 4'd0;
            shift_q  <= '1;
            busy     <= 1'b0;
        end else if (!busy) begin
            if (tx_valid) begin
                // Stop, data, start
                shift_q  <= {1'b1, tx_data, 1'b0};
                baud_cnt <= '0;
                bit_cnt  <= 4'd0;
                busy     <= 1'b1;
            end
        end else if (bit_end) begin
            baud_cnt <= '0;
            shift_q  <= {1'b1, shift_q[9:1]};
            // Free again once the stop bit has run its full time
            if (bit_cnt == 4'd9) begin
                busy <= 1'b0;
            end else begin
                bit_cnt <= bit_cnt + 4'd1;
            end
        end else begin
            baud_cnt <= baud_cnt + 1'b1;
        end
    end

endmodule

//--- tests/tb_clock.sv
`timescale 1ns/100ps

module tb_clock #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 10
) (
    output logic CLOCK_50,
    output logic KEY0
);

    initial begin
        CLOCK_50 = 1'b0;
        forever #(PERIOD_NS / 2) CLOCK_50 = ~CLOCK_50;
    end

    // Release on a falling edge, away from the flops' active edge
    initial begin
        KEY0 = 1'b0;
        repeat (RESET_CYCLES) @(posedge CLOCK_50);
        @(negedge CLOCK_50);
        KEY0 = 1'b1;
    end

endmodule

//--- tests/tb_cpu_on_board.sv
`timescale 1ns/100ps

module tb_cpu_on_board
    import soc_pkg::*;
();

    localparam int baud_div = 16;
    localparam int ps2_half = 40;
    // Four PS/2 frames near 1000 cycles each plus bus and console traffic, over ten times margin
    localparam int max_cycles = 60000;

    logic              CLOCK_50;
    logic              KEY0;
    logic              PS2_CLK;
    logic              PS2_DAT;
    logic [word_w-1:0] pc;
    logic [word_w-1:0] instr;
    logic              bus_valid;
    logic              bus_write;
    logic [xlen-1:0]   bus_addr;
    logic [xlen-1:0]   bus_wdata;
    logic              bus_ready;
    logic [xlen-1:0]   bus_rdata;
    logic              bus_rvalid;
    logic              irq_ack;
    logic [3:0]        irq_vector;
    logic              uart_txd;
    logic              LEDR0;
    logic [5:0]        LEDR_PC;

    int    cycle_cnt = 0;
    int    err_cnt = 0;
    int    check_cnt = 0;
    int    errs_at_start = 0;
    int    tests_passed = 0;
    int    tests_failed = 0;
    string test_name = "";

    tb_clock i_clock (
        .CLOCK_50(CLOCK_50),
        .KEY0    (KEY0)
    );

    cpu_on_board #(
        .MEM_WORDS(2048),
        .BAUD_DIV (baud_div)
    ) i_dut (
        .CLOCK_50  (CLOCK_50),
        .KEY0      (KEY0),
        .PS2_CLK   (PS2_CLK),
        .PS2_DAT   (PS2_DAT),
        .pc        (pc),
        .instr     (instr),
        .bus_valid (bus_valid),
        .bus_write (bus_write),
        .bus_addr  (bus_addr),
        .bus_wdata (bus_wdata),
        .bus_ready (bus_ready),
        .bus_rdata (bus_rdata),
        .bus_rvalid(bus_rvalid),
        .irq_ack   (irq_ack),
        .irq_vector(irq_vector),
        .uart_txd  (uart_txd),
        .LEDR0     (LEDR0),
        .LEDR_PC   (LEDR_PC)
    );

    // Run limit
    always @(posedge CLOCK_50) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == max_cycles) begin
            $display("Timeout in %s after %0d cycles, the DUT stopped answering",
                     test_name, max_cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    task automatic check_value(input string what, input logic [63:0] expected,
                               input logic [63:0] actual);
        check_cnt++;
        assert (actual === expected) else begin
            $display("ERR %s %s expected %h actual %h", test_name, what, expected, actual);
            err_cnt++;
        end
    endtask

    task automatic check_true(input string what, input bit cond);
        check_cnt++;
        assert (cond) else begin
            $display("%s: %s", test_name, what);
            err_cnt++;
        end
    endtask

    task automatic start_test(input string name);
        test_name     = name;
        errs_at_start = err_cnt;
    endtask

    task automatic finish_test();
        if (err_cnt == errs_at_start) begin
            tests_passed++;
            $display("%-22s ok", test_name);
        end else begin
            tests_failed++;
            $display("%-22s failed, %0d errors", test_name, err_cnt - errs_at_start);
        end
    endtask

    // Expected fetch word, bytes in reverse order
    function automatic logic [31:0] swap_bytes(input logic [31:0] w);
        logic [31:0] r;
        for (int b = 0; b < 4; b++) begin
            r[8*b +: 8] = w[8*(3-b) +: 8];
        end
        return r;
    endfunction

    task automatic write_bus(input logic [63:0] addr, input logic [63:0] data,
                             output bit stalled);
        stalled = 1'b0;
        @(negedge CLOCK_50);
        bus_valid = 1'b1;
        bus_write = 1'b1;
        bus_addr  = addr;
        bus_wdata = data;
        // Ready only moves on a rising edge, so 1 ns after the drive it is settled
        #1;
        while (!bus_ready) begin
            stalled = 1'b1;
            @(negedge CLOCK_50);
            #1;
        end
        @(negedge CLOCK_50);
        bus_valid = 1'b0;
        bus_write = 1'b0;
    endtask

    task automatic read_bus(input logic [63:0] addr, output logic [63:0] data);
        @(negedge CLOCK_50);
        bus_valid = 1'b1;
        bus_write = 1'b0;
        bus_addr  = addr;
        #1;
        while (!bus_ready) begin
            @(negedge CLOCK_50);
            #1;
        end
        @(negedge CLOCK_50);
        bus_valid = 1'b0;
        check_true("no read response one cycle after acceptance", bus_rvalid === 1'b1);
        data = bus_rdata;
        @(negedge CLOCK_50);
        check_true("bus_rvalid stayed high for more than one cycle", bus_rvalid === 1'b0);
    endtask

    // Device side of a PS/2 frame, data changes while the clock is high
    task automatic send_ps2_frame(input logic [7:0] code, input bit bad_parity);
        logic [10:0] frame;
        frame = {1'b1, (~^code) ^ bad_parity, code, 1'b0};
        @(negedge CLOCK_50);
        for (int i = 0; i < 11; i++) begin
            PS2_DAT = frame[i];
            repeat (ps2_half) @(negedge CLOCK_50);
            PS2_CLK = 1'b0;
            repeat (ps2_half) @(negedge CLOCK_50);
            PS2_CLK = 1'b1;
        end
        repeat (ps2_half) @(negedge CLOCK_50);
        PS2_DAT = 1'b1;
    endtask

    task automatic wait_for_irq(output bit seen);
        seen = 1'b0;
        for (int n = 0; n < 50 && !seen; n++) begin
            if (irq_vector !== irq_none) begin
                seen = 1'b1;
            end else begin
                @(negedge CLOCK_50);
            end
        end
    endtask

    // Samples each bit near its middle
    task automatic receive_uart_byte(output logic [7:0] data, output bit frame_ok);
        frame_ok = 1'b1;
        while (uart_txd !== 1'b0) @(negedge CLOCK_50);
        repeat (baud_div / 2) @(negedge CLOCK_50);
        if (uart_txd !== 1'b0) frame_ok = 1'b0;
        for (int i = 0; i < 8; i++) begin
            repeat (baud_div) @(negedge CLOCK_50);
            data[i] = uart_txd;
        end
        repeat (baud_div) @(negedge CLOCK_50);
        if (uart_txd !== 1'b1) frame_ok = 1'b0;
    endtask

    task automatic check_reset_state();
        check_value("uart_txd", 1'b1, uart_txd);
        check_value("irq_vector", irq_none, irq_vector);
        check_value("LEDR0", 1'b0, LEDR0);
        check_value("bus_rvalid", 1'b0, bus_rvalid);
        check_value("bus_ready", 1'b1, bus_ready);
    endtask

    task automatic memory_readback();
        logic [63:0] addrs [20];
        logic [31:0] model [logic [63:0]];
        logic [63:0] unmapped [4];
        logic [63:0] wdata;
        logic [63:0] rdata;
        bit          stalled;
        for (int i = 0; i < 20; i++) begin
            addrs[i] = ram_base + 64'(4 * $urandom_range(1023, 0));
            wdata    = {32'($urandom), 32'($urandom)};
            write_bus(addrs[i], wdata, stalled);
            check_true("memory write was stalled", !stalled);
            model[addrs[i]] = wdata[31:0];
        end
        for (int i = 0; i < 20; i++) begin
            read_bus(addrs[i], rdata);
            check_value("ram read", {32'd0, model[addrs[i]]}, rdata);
        end
        unmapped[0] = 64'h0000_0000_0000_3000;
        unmapped[1] = 64'h0000_0000_0000_2010;
        unmapped[2] = 64'h8000_0000_0000_1000;
        unmapped[3] = art_base;
        for (int i = 0; i < 4; i++) begin
            read_bus(unmapped[i], rdata);
            check_value("unmapped read", 64'd0, rdata);
        end
    endtask

    task automatic fetch_swap();
        logic [31:0] word;
        logic [31:0] fetch_pc;
        int          word_idx;
        bit          stalled;
        // One fetch from the instruction area, one from the data area
        for (int n = 0; n < 2; n++) begin
            word     = $urandom;
            word_idx = $urandom_range(1023, 0);
            if (n == 1) word_idx = word_idx + int'(ram_base / 4);
            fetch_pc = 32'(4 * word_idx);
            write_bus({32'd0, fetch_pc}, {32'd0, word}, stalled);
            @(negedge CLOCK_50);
            pc = fetch_pc | 32'($urandom_range(3, 0));
            @(negedge CLOCK_50);
            check_value("instr", swap_bytes(word), instr);
            // LEDs show the low six bits of the word index
            check_value("LEDR_PC", 64'(word_idx % 64), LEDR_PC);
        end
    endtask

    task automatic console_frames();
        logic [7:0] sent [2];
        logic [7:0] got;
        bit         stall_first;
        bit         stall_second;
        bit         frame_ok;
        sent[0] = 8'($urandom);
        sent[1] = 8'($urandom);
        fork
            begin
                write_bus(art_base, {56'd0, sent[0]}, stall_first);
                write_bus(art_base, {56'd0, sent[1]}, stall_second);
            end
            begin
                for (int i = 0; i < 2; i++) begin
                    receive_uart_byte(got, frame_ok);
                    check_true("bad start or stop bit on uart_txd", frame_ok);
                    check_value("console byte", sent[i], got);
                end
            end
        join
        check_true("first console write was held off", !stall_first);
        check_true("bus_ready stayed high during the first frame", stall_second);
    endtask

    task automatic key_press_irq();
        logic [7:0]  code;
        logic [63:0] rdata;
        bit          seen;
        code = 8'($urandom);
        if (code == ps2_break) code = 8'h1C;
        send_ps2_frame(code, 1'b0);
        wait_for_irq(seen);
        check_true("no key interrupt after a make code", seen);
        check_value("irq_vector", irq_key, irq_vector);
        check_value("LEDR0 with interrupt pending", 1'b1, LEDR0);
        read_bus(key_base, rdata);
        check_value("key register", {55'd0, 1'b1, code}, rdata);
        @(negedge CLOCK_50);
        irq_ack = 1'b1;
        @(negedge CLOCK_50);
        irq_ack = 1'b0;
        check_value("irq_vector after ack", irq_none, irq_vector);
        check_value("LEDR0 after ack", 1'b0, LEDR0);
    endtask

    task automatic break_and_bad_frames();
        logic [7:0]  code;
        logic [7:0]  bad_code;
        logic [63:0] rdata;
        code = 8'($urandom);
        if (code == ps2_break) code = 8'h2B;
        bad_code = ~code;
        if (bad_code == ps2_break) bad_code = 8'h1C;
        send_ps2_frame(ps2_break, 1'b0);
        check_value("irq_vector after break prefix", irq_none, irq_vector);
        send_ps2_frame(code, 1'b0);
        check_value("irq_vector after break code", irq_none, irq_vector);
        check_value("LEDR0 after break code", 1'b0, LEDR0);
        read_bus(key_base, rdata);
        check_value("key register after break", {55'd0, 1'b0, code}, rdata);
        // Wrong parity, must be dropped
        send_ps2_frame(bad_code, 1'b1);
        check_value("irq_vector after bad frame", irq_none, irq_vector);
        read_bus(key_base, rdata);
        check_value("key register after bad frame", {55'd0, 1'b0, code}, rdata);
    endtask

    initial begin
        void'($urandom(9570));
        PS2_CLK   = 1'b1;
        PS2_DAT   = 1'b1;
        pc        = '0;
        bus_valid = 1'b0;
        bus_write = 1'b0;
        bus_addr  = '0;
        bus_wdata = '0;
        irq_ack   = 1'b0;

        @(posedge KEY0);
        #1;
        start_test("reset_state");
        check_reset_state();
        finish_test();

        start_test("memory");
        memory_readback();
        finish_test();

        start_test("fetch");
        fetch_swap();
        finish_test();

        start_test("console");
        console_frames();
        finish_test();

        start_test("key_press");
        key_press_irq();
        finish_test();

        start_test("break_and_bad_frames");
        break_and_bad_frames();
        finish_test();

        $display("Summary: %0d tests, %0d passed, %0d failed, %0d checks, %0d errors",
                 tests_passed + tests_failed, tests_passed, tests_failed, check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
